//--- hw/proj_cfg.svh
`ifndef PROJ_CFG_SVH
`define PROJ_CFG_SVH

// Q16.16 fixed-point format
`define PROJ_FBITS 16
`define PROJ_WIDTH 32

// Vertex color width
`define PROJ_COLOR_W 16

// APB register byte offsets
`define PROJ_REG_FOCAL 4'h0
`define PROJ_REG_TRIS 4'h4
`define PROJ_REG_ZERO 4'h8

`endif

//--- hw/proj_pkg.sv
`include "proj_cfg.svh"

package proj_pkg;

    typedef logic signed [`PROJ_WIDTH-1:0] q16_16_t;

    // Magnitudes, |z| and its reciprocal
    typedef logic [`PROJ_WIDTH-1:0] ufix_t;

    typedef logic [`PROJ_COLOR_W-1:0] color_t;

    typedef struct packed {
        q16_16_t x;
        q16_16_t y;
        q16_16_t z;
    } pos_t;

    typedef struct packed {
        pos_t   pos;
        color_t color;
    } vertex_t;

    typedef struct packed {
        vertex_t v0;
        vertex_t v1;
        vertex_t v2;
    } triangle_t;

    typedef enum logic [2:0] {
        IDLE,
        REQ,
        WAIT,
        SCALE,
        STORE
    } proj_state_t;

endpackage

//--- hw/recip_if.sv
`timescale 1ns/1ps

interface recip_if;

    logic              start;
    proj_pkg::ufix_t   divisor;
    logic              done;
    proj_pkg::ufix_t   quotient;

    modport requester (
        output start,
        output divisor,
        input  done,
        input  quotient
    );

    modport server (
        input  start,
        input  divisor,
        output done,
        output quotient
    );

endinterface

//--- hw/fx_reciprocal.sv
`timescale 1ns/1ps
`include "proj_cfg.svh"

module fx_reciprocal (
    input  logic     clk,
    input  logic     rst,
    recip_if.server  req
);

    proj_pkg::ufix_t     rem_q;
    proj_pkg::ufix_t     quot_q;
    logic [5:0]          bit_cnt;
    logic                busy;
    logic                done_q;
    logic [`PROJ_WIDTH:0] rem_shift;
    logic [`PROJ_WIDTH:0] rem_diff;
    logic                fits;
    logic                load;
    logic                step;

    assign load = req.start && !busy;
    assign step = busy && (bit_cnt != `PROJ_WIDTH);

    // Dividend bits below 2^32 are all zero
    always_comb begin
        rem_shift = {rem_q, 1'b0};
        rem_diff  = rem_shift - {1'b0, req.divisor};
        fits      = (rem_shift >= {1'b0, req.divisor});
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            busy    <= 1'b0;
            bit_cnt <= '0;
            done_q  <= 1'b0;
        end else begin
            done_q <= 1'b0;
            if (load) begin
                busy    <= 1'b1;
                bit_cnt <= '0;
            end else if (busy) begin
                if (bit_cnt == `PROJ_WIDTH) begin
                    // Result cycle
                    busy   <= 1'b0;
                    done_q <= 1'b1;
                end else begin
                    bit_cnt <= bit_cnt + 6'd1;
                end
            end
        end
    end

    always_ff @(posedge clk) begin
        if (load) begin
            // Top dividend bit 2^32 handled here, its quotient bit is dropped
            rem_q  <= (req.divisor == 1) ? '0 : proj_pkg::ufix_t'(1);
            quot_q <= '0;
        end else if (step) begin
            rem_q  <= fits ? rem_diff[`PROJ_WIDTH-1:0] : rem_shift[`PROJ_WIDTH-1:0];
            quot_q <= {quot_q[`PROJ_WIDTH-2:0], fits};
        end
    end

    assign req.done     = done_q;
    assign req.quotient = quot_q;

endmodule

//--- hw/triangle_projector.sv
`timescale 1ns/1ps
`include "proj_cfg.svh"

module triangle_projector (
    input  logic                clk,
    input  logic                rst,
    input  proj_pkg::triangle_t in_tri,
    input  logic                in_valid,
    output logic                in_ready,
    input  proj_pkg::q16_16_t   focal,
    output proj_pkg::triangle_t out_tri,
    output logic                out_valid,
    input  logic                out_ready,
    output logic                tri_done,
    output logic                zero_z,
    recip_if.requester          recip
);

    proj_pkg::proj_state_t state;
    logic [1:0]            vcnt;
    proj_pkg::triangle_t   work_tri;
    proj_pkg::q16_16_t     focal_q;
    proj_pkg::ufix_t       recip_q;
    proj_pkg::vertex_t     cur_v;
    proj_pkg::ufix_t       z_abs;
    proj_pkg::q16_16_t     new_x;
    proj_pkg::q16_16_t     new_y;
    logic                  accept;
    logic                  out_free;

    // focal * coord, then times 1/|z|, each step back to Q16.16
    function automatic proj_pkg::q16_16_t scale_coord(
        input proj_pkg::q16_16_t f,
        input proj_pkg::q16_16_t c,
        input proj_pkg::ufix_t   r,
        input logic              neg
    );
        logic signed [63:0] p1;
        logic signed [63:0] p2;
        proj_pkg::q16_16_t  t;
        proj_pkg::q16_16_t  res;
        p1  = f * c;
        t   = p1[`PROJ_WIDTH+`PROJ_FBITS-1:`PROJ_FBITS];
        p2  = t * $signed({1'b0, r});
        res = p2[`PROJ_WIDTH+`PROJ_FBITS-1:`PROJ_FBITS];
        return neg ? -res : res;
    endfunction

    assign in_ready = (state == proj_pkg::IDLE);
    assign accept   = in_valid && in_ready;
    assign out_free = !out_valid || out_ready;

    always_comb begin
        case (vcnt)
            2'd0:    cur_v = work_tri.v0;
            2'd1:    cur_v = work_tri.v1;
            default: cur_v = work_tri.v2;
        endcase
    end

    // z is never rewritten, so the divisor holds until done
    assign z_abs = cur_v.pos.z[`PROJ_WIDTH-1] ? proj_pkg::ufix_t'(-cur_v.pos.z)
                                             : proj_pkg::ufix_t'(cur_v.pos.z);
    assign recip.divisor = (z_abs == '0) ? proj_pkg::ufix_t'(1) : z_abs;
    assign recip.start   = (state == proj_pkg::REQ);

    assign new_x = scale_coord(focal_q, cur_v.pos.x, recip_q, cur_v.pos.z[`PROJ_WIDTH-1]);
    assign new_y = scale_coord(focal_q, cur_v.pos.y, recip_q, cur_v.pos.z[`PROJ_WIDTH-1]);

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            state     <= proj_pkg::IDLE;
            vcnt      <= '0;
            out_valid <= 1'b0;
            tri_done  <= 1'b0;
            zero_z    <= 1'b0;
        end else begin
            tri_done <= 1'b0;
            zero_z   <= 1'b0;
            if (out_valid && out_ready) begin
                out_valid <= 1'b0;
            end
            case (state)
                proj_pkg::IDLE: begin
                    if (accept) begin
                        vcnt  <= '0;
                        state <= proj_pkg::REQ;
                    end
                end
                proj_pkg::REQ: begin
                    zero_z <= (cur_v.pos.z == '0);
                    state  <= proj_pkg::WAIT;
                end
                proj_pkg::WAIT: begin
                    if (recip.done) begin
                        state <= proj_pkg::SCALE;
                    end
                end
                proj_pkg::SCALE: begin
                    if (vcnt == 2'd2) begin
                        state <= proj_pkg::STORE;
                    end else begin
                        vcnt  <= vcnt + 2'd1;
                        state <= proj_pkg::REQ;
                    end
                end
                proj_pkg::STORE: begin
                    // Hold here while the previous triangle is still unread
                    if (out_free) begin
                        out_valid <= 1'b1;
                        tri_done  <= 1'b1;
                        state     <= proj_pkg::IDLE;
                    end
                end
                default: state <= proj_pkg::IDLE;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (accept) begin
            work_tri <= in_tri;
            focal_q  <= focal;
        end
        if (state == proj_pkg::WAIT && recip.done) begin
            recip_q <= recip.quotient;
        end
        if (state == proj_pkg::SCALE) begin
            case (vcnt)
                2'd0: begin
                    work_tri.v0.pos.x <= new_x;
                    work_tri.v0.pos.y <= new_y;
                end
                2'd1: begin
                    work_tri.v1.pos.x <= new_x;
                    work_tri.v1.pos.y <= new_y;
                end
                default: begin
                    work_tri.v2.pos.x <= new_x;
                    work_tri.v2.pos.y <= new_y;
                end
            endcase
        end
        if (state == proj_pkg::STORE && out_free) begin
            out_tri <= work_tri;
        end
    end

endmodule

//--- hw/proj_apb_regs.sv
`timescale 1ns/1ps
`include "proj_cfg.svh"

module proj_apb_regs (
    input  logic              clk,
    input  logic              rst,
    input  logic              psel,
    input  logic              penable,
    input  logic              pwrite,
    input  logic [3:0]        paddr,
    input  logic [31:0]       pwdata,
    output logic [31:0]       prdata,
    output logic              pready,
    output logic              pslverr,
    output proj_pkg::q16_16_t focal,
    input  logic              tri_done,
    input  logic              zero_z
);

    logic [31:0] tri_cnt;
    logic [31:0] zero_cnt;
    logic [31:0] rd_data;
    logic        hit;
    logic        wr_en;

    always_comb begin
        hit = 1'b1;
        case (paddr)
            `PROJ_REG_FOCAL: rd_data = focal;
            `PROJ_REG_TRIS:  rd_data = tri_cnt;
            `PROJ_REG_ZERO:  rd_data = zero_cnt;
            default: begin
                rd_data = '0;
                hit     = 1'b0;
            end
        endcase
    end

    assign wr_en   = psel && penable && pwrite && hit;
    assign prdata  = (psel && !pwrite) ? rd_data : '0;
    assign pready  = 1'b1;
    assign pslverr = psel && penable && !hit;

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            focal    <= proj_pkg::q16_16_t'(1 << `PROJ_FBITS);
            tri_cnt  <= '0;
            zero_cnt <= '0;
        end else begin
            if (wr_en && paddr == `PROJ_REG_FOCAL) begin
                focal <= pwdata;
            end
            // Clear beats a same-cycle event
            if (wr_en && paddr == `PROJ_REG_TRIS) begin
                tri_cnt <= '0;
            end else if (tri_done) begin
                tri_cnt <= tri_cnt + 32'd1;
            end
            if (wr_en && paddr == `PROJ_REG_ZERO) begin
                zero_cnt <= '0;
            end else if (zero_z) begin
                zero_cnt <= zero_cnt + 32'd1;
            end
        end
    end

endmodule

//--- hw/proj_top.sv
`timescale 1ns/1ps

module proj_top (
    input  logic                clk,
    input  logic                rst,
    input  logic                psel,
    input  logic                penable,
    input  logic                pwrite,
    input  logic [3:0]          paddr,
    input  logic [31:0]         pwdata,
    output logic [31:0]         prdata,
    output logic                pready,
    output logic                pslverr,
    input  proj_pkg::triangle_t in_tri,
    input  logic                in_valid,
    output logic                in_ready,
    output proj_pkg::triangle_t out_tri,
    output logic                out_valid,
    input  logic                out_ready
);

    proj_pkg::q16_16_t focal;
    logic              tri_done;
    logic              zero_z;

    recip_if recip_bus ();

    fx_reciprocal u_recip (
        .clk (clk),
        .rst (rst),
        .req (recip_bus.server)
    );

    triangle_projector u_proj (
        .clk       (clk),
        .rst       (rst),
        .in_tri    (in_tri),
        .in_valid  (in_valid),
        .in_ready  (in_ready),
        .focal     (focal),
        .out_tri   (out_tri),
        .out_valid (out_valid),
        .out_ready (out_ready),
        .tri_done  (tri_done),
        .zero_z    (zero_z),
        .recip     (recip_bus.requester)
    );

    proj_apb_regs u_regs (
        .clk      (clk),
        .rst      (rst),
        .psel     (psel),
        .penable  (penable),
        .pwrite   (pwrite),
        .paddr    (paddr),
        .pwdata   (pwdata),
        .prdata   (prdata),
        .pready   (pready),
        .pslverr  (pslverr),
        .focal    (focal),
        .tri_done (tri_done),
        .zero_z   (zero_z)
    );

endmodule

//--- bench/proj_tb.sv
`timescale 1ns/1ps
`include "proj_cfg.svh"

module proj_tb;

    logic                clk;
    logic                rst;
    logic                psel;
    logic                penable;
    logic                pwrite;
    logic [3:0]          paddr;
    logic [31:0]         pwdata;
    logic [31:0]         prdata;
    logic                pready;
    logic                pslverr;
    proj_pkg::triangle_t in_tri;
    logic                in_valid;
    logic                in_ready;
    proj_pkg::triangle_t out_tri;
    logic                out_valid;
    logic                out_ready;
    integer              seed;
    proj_pkg::q16_16_t   cur_focal;
    int                  tris_sent;

    proj_top UUT (.*);

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    task automatic check(input string name, input logic [335:0] expected,
                         input logic [335:0] actual);
        if (expected !== actual) begin
            $display("[FAIL] %s expected %0h actual %0h", name, expected, actual);
            $display("Regression failed");
            $fatal(1, "Mismatch in %s", name);
        end
    endtask

    task automatic timeout_stop(input string what);
        $display("No %s within 2000 cycles, the DUT appears stuck", what);
        $display("Regression failed");
        $fatal(1, "Timeout");
    endtask

    task automatic apb_transfer(input logic wr, input logic [3:0] addr, input logic [31:0] wdata,
                                output logic [31:0] rdata, output logic err);
        int waited;
        @(negedge clk);
        psel   = 1'b1;
        pwrite = wr;
        paddr  = addr;
        pwdata = wdata;
        @(negedge clk);
        penable = 1'b1;
        #1;
        waited = 0;
        while (!pready) begin
            if (waited == 2000) timeout_stop("APB pready");
            @(negedge clk);
            #1;
            waited++;
        end
        rdata = prdata;
        err   = pslverr;
        @(negedge clk);
        psel    = 1'b0;
        penable = 1'b0;
        pwrite  = 1'b0;
    endtask

    task automatic apb_write(input logic [3:0] addr, input logic [31:0] data, output logic err);
        logic [31:0] rd_ignored;
        apb_transfer(1'b1, addr, data, rd_ignored, err);
    endtask

    task automatic apb_read(input logic [3:0] addr, output logic [31:0] data, output logic err);
        apb_transfer(1'b0, addr, 32'h0, data, err);
    endtask

    task automatic set_focal(input proj_pkg::q16_16_t value);
        logic err;
        apb_write(`PROJ_REG_FOCAL, value, err);
        check("FOCAL write pslverr", 1'b0, err);
        cur_focal = value;
    endtask

    task automatic read_reg(input string name, input logic [3:0] addr, input logic [31:0] expected);
        logic [31:0] data;
        logic        err;
        apb_read(addr, data, err);
        check({name, " pslverr"}, 1'b0, err);
        check(name, expected, data);
    endtask

    task automatic send_tri(input proj_pkg::triangle_t t);
        int waited;
        @(negedge clk);
        in_tri   = t;
        in_valid = 1'b1;
        waited   = 0;
        while (!in_ready) begin
            if (waited == 2000) timeout_stop("in_ready");
            @(negedge clk);
            waited++;
        end
        @(negedge clk);
        in_valid = 1'b0;
        tris_sent++;
    endtask

    task automatic recv_tri(output proj_pkg::triangle_t t);
        int waited;
        @(negedge clk);
        out_ready = 1'b1;
        waited    = 0;
        while (!out_valid) begin
            if (waited == 2000) timeout_stop("out_valid");
            @(negedge clk);
            waited++;
        end
        t = out_tri;
        @(negedge clk);
        out_ready = 1'b0;
    endtask

    // Signed product back to Q16.16, low word kept
    function automatic proj_pkg::q16_16_t fx_mul(input longint a, input longint b);
        longint p;
        p = a * b;
        return proj_pkg::q16_16_t'(p >>> `PROJ_FBITS);
    endfunction

    function automatic proj_pkg::vertex_t model_vertex(input proj_pkg::vertex_t v,
                                                        input proj_pkg::q16_16_t f);
        proj_pkg::vertex_t o;
        longint            mag;
        longint            inv;
        o   = v;
        mag = $signed(v.pos.z);
        if (mag < 0) mag = -mag;
        if (mag == 0) mag = 1;
        inv = ((longint'(1) << 32) / mag) % (longint'(1) << 32);
        o.pos.x = fx_mul(fx_mul(f, $signed(v.pos.x)), inv);
        o.pos.y = fx_mul(fx_mul(f, $signed(v.pos.y)), inv);
        if (v.pos.z[`PROJ_WIDTH-1]) begin
            o.pos.x = -o.pos.x;
            o.pos.y = -o.pos.y;
        end
        return o;
    endfunction

    function automatic proj_pkg::triangle_t model_tri(input proj_pkg::triangle_t t,
                                                       input proj_pkg::q16_16_t f);
        proj_pkg::triangle_t o;
        o.v0 = model_vertex(t.v0, f);
        o.v1 = model_vertex(t.v1, f);
        o.v2 = model_vertex(t.v2, f);
        return o;
    endfunction

    function automatic proj_pkg::vertex_t make_vertex(input logic [31:0] x, input logic [31:0] y,
                                                       input logic [31:0] z, input logic [15:0] c);
        proj_pkg::vertex_t v;
        v.pos.x = x;
        v.pos.y = y;
        v.pos.z = z;
        v.color = c;
        return v;
    endfunction

    task automatic rand_tri(output proj_pkg::triangle_t t);
        logic [351:0] bits;
        for (int i = 0; i < 11; i++) bits[i*32 +: 32] = $random(seed);
        t = bits[335:0];
    endtask

    task automatic project_and_check(input string name, input proj_pkg::triangle_t t);
        proj_pkg::triangle_t got;
        send_tri(t);
        recv_tri(got);
        check(name, model_tri(t, cur_focal), got);
    endtask

    task automatic test_registers();
        logic [31:0] data;
        logic        err;
        read_reg("reset FOCAL", `PROJ_REG_FOCAL, 32'h0001_0000);
        read_reg("reset TRIS", `PROJ_REG_TRIS, 32'h0);
        read_reg("reset ZERO", `PROJ_REG_ZERO, 32'h0);
        set_focal(32'h0003_8000);
        read_reg("FOCAL readback", `PROJ_REG_FOCAL, 32'h0003_8000);
        apb_read(4'hC, data, err);
        check("unmapped pslverr", 1'b1, err);
        check("unmapped prdata", 32'h0, data);
    endtask

    task automatic test_single();
        proj_pkg::triangle_t t;
        set_focal(32'h0002_0000);
        t.v0 = make_vertex(32'h0001_0000, 32'hFFFF_8000, 32'h0002_0000, 16'h1234);
        t.v1 = make_vertex(32'h0004_4000, 32'h0000_2000, 32'h0000_8000, 16'hABCD);
        t.v2 = make_vertex(32'hFFFD_0000, 32'h0007_0000, 32'h0003_0000, 16'h0F0F);
        project_and_check("positive z triangle", t);
        read_reg("TRIS after one", `PROJ_REG_TRIS, 32'd1);
    endtask

    task automatic test_sign_zero();
        proj_pkg::triangle_t t;
        logic                err;
        t.v0 = make_vertex(32'h0003_0000, 32'h0001_4000, 32'h0004_0000, 16'hF800);
        t.v1 = make_vertex(32'hFFFE_0000, 32'h0002_0000, 32'hFFFE_0000, 16'h07E0);
        t.v2 = make_vertex(32'h0001_0000, 32'hFFFF_0000, 32'h0001_0000, 16'h001F);
        project_and_check("negative z triangle", t);
        t.v1.pos.z = 32'h0;
        project_and_check("zero z triangle", t);
        read_reg("ZERO count", `PROJ_REG_ZERO, 32'd1);
        apb_write(`PROJ_REG_ZERO, 32'hDEAD_BEEF, err);
        check("ZERO clear pslverr", 1'b0, err);
        read_reg("ZERO cleared", `PROJ_REG_ZERO, 32'd0);
    endtask

    task automatic test_backpressure();
        proj_pkg::triangle_t a;
        proj_pkg::triangle_t b;
        proj_pkg::triangle_t got_a;
        proj_pkg::triangle_t got_b;
        rand_tri(a);
        rand_tri(b);
        send_tri(a);
        send_tri(b);
        // Long enough for the second triangle to reach STORE
        repeat (150) @(negedge clk);
        check("stalled in_ready", 1'b0, in_ready);
        check("held out_valid", 1'b1, out_valid);
        recv_tri(got_a);
        recv_tri(got_b);
        check("first held triangle", model_tri(a, cur_focal), got_a);
        check("second held triangle", model_tri(b, cur_focal), got_b);
    endtask

    task automatic test_random();
        proj_pkg::triangle_t t;
        logic [31:0]         base;
        base = tris_sent;
        for (int n = 0; n < 20; n++) begin
            set_focal($random(seed));
            rand_tri(t);
            project_and_check("random triangle", t);
        end
        read_reg("TRIS after random", `PROJ_REG_TRIS, base + 32'd20);
    endtask

    initial begin
        seed      = 32'h4e773627;
        tris_sent = 0;
        rst       = 1'b1;
        psel      = 1'b0;
        penable   = 1'b0;
        pwrite    = 1'b0;
        paddr     = 4'h0;
        pwdata    = 32'h0;
        in_tri    = '0;
        in_valid  = 1'b0;
        out_ready = 1'b0;
        cur_focal = 32'h0001_0000;
        repeat (3) @(negedge clk);
        rst = 1'b0;
        test_registers();
        test_single();
        test_sign_zero();
        test_backpressure();
        test_random();
        $display("Regression passed");
        $finish;
    end

endmodule

//--- proj_top.f
+incdir+hw
hw/proj_pkg.sv
hw/recip_if.sv
hw/fx_reciprocal.sv
hw/triangle_projector.sv
hw/proj_apb_regs.sv
hw/proj_top.sv
bench/proj_tb.sv

//--- run_sim.sh
#!/usr/bin/env bash
# Build the projection testbench with Verilator and run it

cd "$(dirname "$0")" || exit 1

verilator --binary -Wno-fatal --top-module proj_tb -f proj_top.f -o proj_sim
build_status=$?
if [ $build_status -ne 0 ]; then
    echo "Verilator build failed with status $build_status"
    exit 1
fi

sim_out=$(./obj_dir/proj_sim 2>&1)
sim_status=$?
echo "$sim_out"
if [ $sim_status -ne 0 ]; then
    echo "Simulation exited with status $sim_status"
    exit 1
fi

if echo "$sim_out" | grep -q "Regression passed"; then
    exit 0
else
    echo "Pass message not found in simulation output"
    exit 1
fi
